// File: hdl/cache_ctrl_fsm.sv
// Cache controller
`timescale 1ns/1ps
`include "l1_cache_cfg.svh"

module cache_ctrl_fsm (
    input  logic                      CLK,
    input  logic                      nRST,
    input  l1_cache_pkg::cpu_req_t    req,
    input  logic                      flush,
    input  l1_cache_pkg::mem_rsp_t    mem_rsp,
    input  l1_cache_pkg::cache_addr_t lk_dec,
    input  logic                      hit,
    input  logic                      pass_through,
    input  l1_cache_pkg::word_t       hit_word,
    input  l1_cache_pkg::frame_t      frame,
    input  l1_cache_pkg::frame_t      write_frame,
    input  l1_cache_pkg::frame_t      fill_frame,
    input  l1_cache_pkg::word_t       pass_wdata,
    input  l1_cache_pkg::set_idx_t    walk_set,
    input  logic                      walk_finish,
    output l1_cache_pkg::cpu_rsp_t    rsp,
    output l1_cache_pkg::mem_req_t    mem_req,
    output l1_cache_pkg::set_idx_t    store_sel,
    output logic                      store_wen,
    output l1_cache_pkg::frame_t      store_wval,
    output l1_cache_pkg::frame_t      store_wmask,
    output logic                      walk_clear,
    output logic                      walk_step,
    output logic                      flush_done
);
    import l1_cache_pkg::*;

    localparam set_idx_t LAST_SET = set_idx_t'(`L1_N_SETS - 1);

    ctrl_state_t state, next_state;
    addr_t       addr_q, next_addr;
    logic        flush_req, next_flush_req;
    cache_addr_t fetch_addr;
    cache_addr_t victim_addr;
    cache_addr_t walk_addr;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            addr_q    <= '0;
            flush_req <= 1'b0;
        end else begin
            state     <= next_state;
            addr_q    <= next_addr;
            flush_req <= next_flush_req;
        end
    end

    // block aligned addresses for the memory port
    always_comb begin
        fetch_addr          = lk_dec;
        fetch_addr.word     = '0;
        fetch_addr.byte_off = '0;
        victim_addr         = fetch_addr;
        victim_addr.tag     = frame.tag.tag;
        walk_addr           = '0;
        walk_addr.tag       = frame.tag.tag;
        walk_addr.set       = walk_set;
    end

    always_comb begin
        next_state      = state;
        next_addr       = addr_q;
        rsp.busy        = 1'b1;
        rsp.rdata       = '0;
        mem_req.ren     = 1'b0;
        mem_req.wen     = 1'b0;
        mem_req.addr    = addr_q;
        mem_req.wdata   = frame.data;
        mem_req.byte_en = '1;
        store_sel       = lk_dec.set;
        store_wen       = 1'b0;
        store_wval      = '0;
        store_wmask     = '1;
        walk_clear      = 1'b0;
        walk_step       = 1'b0;
        flush_done      = 1'b0;

        case (state)
            IDLE: begin
                // invalidate one set per cycle after reset
                store_sel   = walk_set;
                store_wen   = 1'b1;
                store_wmask = '0;
                walk_step   = 1'b1;
                if (walk_set == LAST_SET) begin
                    next_state = HIT;
                end
            end
            HIT: begin
                walk_clear = 1'b1;
                // finish left over from the reset walk
                flush_done = walk_finish;
                if (flush || flush_req) begin
                    next_state = FLUSH_CACHE;
                end else if (req.ren || req.wen) begin
                    if (pass_through) begin
                        mem_req.ren     = req.ren;
                        mem_req.wen     = req.wen;
                        mem_req.addr    = req.addr;
                        mem_req.wdata   = {`L1_BLOCK_WORDS{pass_wdata}};
                        mem_req.byte_en = req.byte_en;
                        rsp.busy        = mem_rsp.busy;
                        rsp.rdata       = mem_rsp.rdata[lk_dec.word];
                    end else if (hit) begin
                        rsp.busy = 1'b0;
                        if (req.wen) begin
                            store_wen                     = 1'b1;
                            store_wval                    = write_frame;
                            store_wmask.tag.dirty         = 1'b0;
                            store_wmask.data[lk_dec.word] = '0;
                        end else begin
                            rsp.rdata = hit_word;
                        end
                    end else if (frame.tag.valid && frame.tag.dirty) begin
                        next_addr  = addr_t'(victim_addr);
                        next_state = WB;
                    end else begin
                        next_addr  = addr_t'(fetch_addr);
                        next_state = FETCH;
                    end
                end
            end
            FETCH: begin
                mem_req.ren = 1'b1;
                if (!mem_rsp.busy) begin
                    store_wen   = 1'b1;
                    store_wval  = fill_frame;
                    store_wmask = '0;
                    next_state  = HIT;
                end
            end
            WB: begin
                mem_req.wen = 1'b1;
                if (!mem_rsp.busy) begin
                    // victim leaves clean and invalid, retry then fetches
                    store_wen             = 1'b1;
                    store_wmask.tag.valid = 1'b0;
                    store_wmask.tag.dirty = 1'b0;
                    next_state            = HIT;
                end
            end
            FLUSH_CACHE: begin
                store_sel = walk_set;
                if (walk_finish) begin
                    flush_done = 1'b1;
                    walk_clear = 1'b1;
                    next_state = HIT;
                end else if (frame.tag.valid && frame.tag.dirty) begin
                    mem_req.wen  = 1'b1;
                    mem_req.addr = addr_t'(walk_addr);
                    if (!mem_rsp.busy) begin
                        store_wen   = 1'b1;
                        store_wmask = '0;
                        walk_step   = 1'b1;
                    end
                end else begin
                    store_wen   = 1'b1;
                    store_wmask = '0;
                    walk_step   = 1'b1;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // flush request held until the walk completes
    always_comb begin
        next_flush_req = flush_req;
        if (flush) begin
            next_flush_req = 1'b1;
        end
        if (state == FLUSH_CACHE && walk_finish) begin
            next_flush_req = 1'b0;
        end
    end

endmodule

// File: hdl/cache_frame_store.sv
// Cache frame store
`timescale 1ns/1ps
`include "l1_cache_cfg.svh"

module cache_frame_store (
    input  logic                  CLK,
    input  logic                  nRST,
    input  l1_cache_pkg::set_idx_t sel,
    input  logic                  wen,
    input  l1_cache_pkg::frame_t  wval,
    input  l1_cache_pkg::frame_t  wmask,
    output l1_cache_pkg::frame_t  rval
);
    import l1_cache_pkg::*;

    // tag and data words kept apart from the state flags
    typedef struct packed {
        tag_bits_t tag;
        block_t    data;
    } payload_t;

    payload_t                arr [`L1_N_SETS];
    logic [`L1_N_SETS-1:0]   valid_q;
    logic [`L1_N_SETS-1:0]   dirty_q;
    payload_t                cur_p;
    payload_t                wr_p;
    payload_t                mask_p;

    assign cur_p  = arr[sel];
    assign wr_p   = {wval.tag.tag, wval.data};
    assign mask_p = {wmask.tag.tag, wmask.data};

    always_comb begin
        rval.tag.valid = valid_q[sel];
        rval.tag.dirty = dirty_q[sel];
        rval.tag.tag   = cur_p.tag;
        rval.data      = cur_p.data;
    end

    // a mask bit of 0 lets the new bit through
    always_ff @(posedge CLK) begin
        if (wen) begin
            arr[sel] <= (cur_p & mask_p) | (wr_p & ~mask_p);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wen) begin
            if (!wmask.tag.valid) begin
                valid_q[sel] <= wval.tag.valid;
            end
            if (!wmask.tag.dirty) begin
                dirty_q[sel] <= wval.tag.dirty;
            end
        end
    end

endmodule

// File: hdl/cache_lookup.sv
// Cache lookup and byte lane merge
`timescale 1ns/1ps
`include "l1_cache_cfg.svh"

module cache_lookup (
    input  l1_cache_pkg::cpu_req_t    req,
    input  l1_cache_pkg::frame_t      frame,
    input  l1_cache_pkg::block_t      mem_block,
    output l1_cache_pkg::cache_addr_t dec,
    output logic                      hit,
    output logic                      pass_through,
    output l1_cache_pkg::word_t       hit_word,
    output l1_cache_pkg::frame_t      write_frame,
    output l1_cache_pkg::frame_t      fill_frame,
    output l1_cache_pkg::word_t       pass_wdata
);
    import l1_cache_pkg::*;

    word_t lane_mask;

    function automatic word_t merge_lanes(word_t old_w, word_t new_w, word_t mask);
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    assign dec = cache_addr_t'(req.addr);

    // uncached region sits at the top of the address map
    assign pass_through = req.addr >= `L1_NONCACHE_START;

    assign hit = !pass_through && frame.tag.valid && (frame.tag.tag == dec.tag);

    assign hit_word = frame.data[dec.word];

    // one byte of mask per enabled lane
    always_comb begin
        lane_mask = '0;
        for (int i = 0; i < `L1_WORD_BITS / 8; i++) begin
            lane_mask[8*i +: 8] = {8{req.byte_en[i]}};
        end
    end

    // write hit keeps the frame and merges the new lanes
    always_comb begin
        write_frame = frame;
        write_frame.data[dec.word] = merge_lanes(frame.data[dec.word], req.wdata,
                                                 lane_mask);
        write_frame.tag.dirty = 1'b1;
    end

    // fill takes the fetched block, pending write lanes on top
    always_comb begin
        fill_frame.tag.valid = 1'b1;
        fill_frame.tag.dirty = req.wen;
        fill_frame.tag.tag   = dec.tag;
        fill_frame.data      = mem_block;
        if (req.wen) begin
            fill_frame.data[dec.word] = merge_lanes(mem_block[dec.word], req.wdata,
                                                    lane_mask);
        end
    end

    // disabled lanes go out as zero
    assign pass_wdata = req.wdata & lane_mask;

endmodule

// File: hdl/flush_counter.sv
// Set index walker
`timescale 1ns/1ps
`include "l1_cache_cfg.svh"

module flush_counter (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   clear,
    input  logic                   step,
    output l1_cache_pkg::set_idx_t set_num,
    output logic                   finish
);
    localparam l1_cache_pkg::set_idx_t LAST_SET =
        l1_cache_pkg::set_idx_t'(`L1_N_SETS - 1);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            set_num <= '0;
            finish  <= 1'b0;
        end else if (clear) begin
            set_num <= '0;
            finish  <= 1'b0;
        end else if (step && !finish) begin
            // finish holds until the next clear
            if (set_num == LAST_SET) begin
                set_num <= '0;
                finish  <= 1'b1;
            end else begin
                set_num <= set_num + 1'b1;
            end
        end
    end

endmodule

// File: hdl/l1_cache.sv
// L1 data cache top
`timescale 1ns/1ps
`include "l1_cache_cfg.svh"

module l1_cache (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::cpu_req_t cpu_req,
    output l1_cache_pkg::cpu_rsp_t cpu_rsp,
    output l1_cache_pkg::mem_req_t mem_req,
    input  l1_cache_pkg::mem_rsp_t mem_rsp,
    input  logic                   flush,
    output logic                   flush_done
);
    l1_cache_pkg::cache_addr_t lk_dec;
    logic                      hit;
    logic                      pass_through;
    l1_cache_pkg::word_t       hit_word;
    l1_cache_pkg::word_t       pass_wdata;
    l1_cache_pkg::frame_t      frame;
    l1_cache_pkg::frame_t      write_frame;
    l1_cache_pkg::frame_t      fill_frame;
    l1_cache_pkg::set_idx_t    store_sel;
    logic                      store_wen;
    l1_cache_pkg::frame_t      store_wval;
    l1_cache_pkg::frame_t      store_wmask;
    l1_cache_pkg::set_idx_t    walk_set;
    logic                      walk_finish;
    logic                      walk_clear;
    logic                      walk_step;

    cache_lookup u_lookup (
        .req          (cpu_req),
        .frame        (frame),
        .mem_block    (mem_rsp.rdata),
        .dec          (lk_dec),
        .hit          (hit),
        .pass_through (pass_through),
        .hit_word     (hit_word),
        .write_frame  (write_frame),
        .fill_frame   (fill_frame),
        .pass_wdata   (pass_wdata)
    );

    cache_frame_store u_store (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (store_sel),
        .wen   (store_wen),
        .wval  (store_wval),
        .wmask (store_wmask),
        .rval  (frame)
    );

    flush_counter u_walk (
        .CLK     (CLK),
        .nRST    (nRST),
        .clear   (walk_clear),
        .step    (walk_step),
        .set_num (walk_set),
        .finish  (walk_finish)
    );

    cache_ctrl_fsm u_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .req          (cpu_req),
        .flush        (flush),
        .mem_rsp      (mem_rsp),
        .lk_dec       (lk_dec),
        .hit          (hit),
        .pass_through (pass_through),
        .hit_word     (hit_word),
        .frame        (frame),
        .write_frame  (write_frame),
        .fill_frame   (fill_frame),
        .pass_wdata   (pass_wdata),
        .walk_set     (walk_set),
        .walk_finish  (walk_finish),
        .rsp          (cpu_rsp),
        .mem_req      (mem_req),
        .store_sel    (store_sel),
        .store_wen    (store_wen),
        .store_wval   (store_wval),
        .store_wmask  (store_wmask),
        .walk_clear   (walk_clear),
        .walk_step    (walk_step),
        .flush_done   (flush_done)
    );

endmodule

// File: hdl/l1_cache_cfg.svh
// L1 data cache configuration
`ifndef L1_CACHE_CFG_SVH
`define L1_CACHE_CFG_SVH

// capacity in bits, power of two
`define L1_CACHE_BITS 1024

// words per block, power of two, at least 2
`define L1_BLOCK_WORDS 2

`define L1_WORD_BITS 32

// first uncached byte address
`define L1_NONCACHE_START 32'hF000_0000

// derived geometry
`define L1_N_SETS ((`L1_CACHE_BITS / `L1_WORD_BITS) / `L1_BLOCK_WORDS)
`define L1_SET_BITS $clog2(`L1_N_SETS)
`define L1_BLOCK_BITS $clog2(`L1_BLOCK_WORDS)
`define L1_TAG_BITS (`L1_WORD_BITS - `L1_SET_BITS - `L1_BLOCK_BITS - 2)

`endif

// File: hdl/l1_cache_pkg.sv
// L1 data cache types
`include "l1_cache_cfg.svh"

package l1_cache_pkg;

    typedef logic [`L1_WORD_BITS-1:0]   word_t;
    typedef logic [`L1_WORD_BITS-1:0]   addr_t;
    typedef logic [`L1_WORD_BITS/8-1:0] byte_en_t;
    typedef logic [`L1_SET_BITS-1:0]    set_idx_t;
    typedef logic [`L1_TAG_BITS-1:0]    tag_bits_t;
    typedef word_t [`L1_BLOCK_WORDS-1:0] block_t;

    // byte address split into cache fields
    typedef struct packed {
        tag_bits_t                tag;
        set_idx_t                 set;
        logic [`L1_BLOCK_BITS-1:0] word;
        logic [1:0]               byte_off;
    } cache_addr_t;

    typedef struct packed {
        logic      valid;
        logic      dirty;
        tag_bits_t tag;
    } frame_tag_t;

    typedef struct packed {
        frame_tag_t tag;
        block_t     data;
    } frame_t;

    typedef struct packed {
        logic     ren;
        logic     wen;
        addr_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } cpu_rsp_t;

    // block wide memory side
    typedef struct packed {
        logic     ren;
        logic     wen;
        addr_t    addr;
        block_t   wdata;
        byte_en_t byte_en;
    } mem_req_t;

    typedef struct packed {
        logic   busy;
        block_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        HIT,
        FETCH,
        WB,
        FLUSH_CACHE
    } ctrl_state_t;

endpackage

// File: project.f
+incdir+hdl
hdl/l1_cache_pkg.sv
hdl/cache_frame_store.sv
hdl/cache_lookup.sv
hdl/flush_counter.sv
hdl/cache_ctrl_fsm.sv
hdl/l1_cache.sv
verification/mem_responder.sv
verification/l1_cache_tb.sv

// File: verification/l1_cache_tb.sv
// L1 data cache testbench
`timescale 1ns/1ps
`include "l1_cache_cfg.svh"

module l1_cache_tb;
    import l1_cache_pkg::*;

    localparam int    BLOCK_BYTES = `L1_BLOCK_WORDS * 4;
    localparam int    N_RANDOM    = 300;
    localparam int    N_CONFLICT  = 48;
    localparam int    N_FLUSH_WR  = 40;
    localparam int    N_PASS      = 40;
    localparam int    OP_COUNT    = 17 + N_RANDOM + 14 + 3 * N_CONFLICT + N_FLUSH_WR + 1 + N_PASS;
    localparam addr_t PASS_BASE   = `L1_NONCACHE_START + 32'h800;

    logic     CLK;
    logic     nRST;
    logic     flush;
    logic     flush_done;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    word_t model [1024];
    string cur_test;
    int    errors;
    int    checks;
    int    test_errors;
    int    tests_run;
    int    tests_failed;
    int    done_count;

    l1_cache u_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .flush      (flush),
        .flush_done (flush_done)
    );

    mem_responder u_mem (
        .CLK     (CLK),
        .nRST    (nRST),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        if (nRST && flush_done) begin
            done_count++;
        end
    end

    initial begin
        repeat (200 * OP_COUNT) @(posedge CLK);
        $display("timeout: run did not end within %0d cycles", 200 * OP_COUNT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic int word_index(addr_t addr);
        return int'(addr[11:2]);
    endfunction

    function automatic word_t lane_merge(word_t old_w, word_t new_w, byte_en_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    // request held until a cycle with busy low
    task automatic cpu_access(input logic is_write, input addr_t addr, input word_t wdata,
                              input byte_en_t be, output word_t rdata);
        @(posedge CLK);
        cpu_req.ren     <= !is_write;
        cpu_req.wen     <= is_write;
        cpu_req.addr    <= addr;
        cpu_req.wdata   <= wdata;
        cpu_req.byte_en <= be;
        @(negedge CLK);
        while (cpu_rsp.busy) begin
            @(negedge CLK);
        end
        rdata = cpu_rsp.rdata;
        @(posedge CLK);
        cpu_req.ren <= 1'b0;
        cpu_req.wen <= 1'b0;
        if (is_write) begin
            model[word_index(addr)] = lane_merge(model[word_index(addr)], wdata, be);
        end
    endtask

    task automatic cpu_read(input addr_t addr);
        word_t rdata;
        cpu_access(1'b0, addr, '0, '1, rdata);
        check_value(cur_test, model[word_index(addr)], rdata);
    endtask

    task automatic cpu_write(input addr_t addr, input word_t wdata, input byte_en_t be);
        word_t unused_rdata;
        cpu_access(1'b1, addr, wdata, be, unused_rdata);
    endtask

    task automatic wait_flush_done(input int target, input int limit);
        int n;
        n = 0;
        while (done_count < target && n < limit) begin
            @(negedge CLK);
            n++;
        end
        if (done_count < target) begin
            errors++;
            $display("%s: flush_done did not pulse within %0d cycles", cur_test, limit);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("%-12s : pass", cur_test);
        end else begin
            tests_failed++;
            $display("%-12s : fail, %0d errors", cur_test, errors - test_errors);
        end
    endtask

    initial begin
        addr_t    addr_a;
        addr_t    addr_b;
        int       set_n;
        int       word_n;
        int       tag_a;
        int       tag_b;
        int       prev_done;
        byte_en_t lanes [7];

        void'($urandom(32'hfd99335c));
        lanes        = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
        nRST         = 1'b0;
        flush        = 1'b0;
        cpu_req      = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        done_count   = 0;
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
        for (int i = 0; i < 1024; i++) begin
            model[i] = u_mem.mem[i];
        end

        // clearing walk ends with one flush_done
        start_test("reset_clear");
        wait_flush_done(1, 64);
        repeat (8) @(posedge CLK);
        check_value({cur_test, " pulses"}, 1, done_count);
        for (int s = 0; s < `L1_N_SETS; s++) begin
            cpu_read(addr_t'(s * BLOCK_BYTES));
        end
        end_test();

        start_test("random_rw");
        for (int i = 0; i < N_RANDOM; i++) begin
            addr_a = addr_t'($urandom_range(63, 0) * 4);
            if ($urandom_range(1, 0) == 1) begin
                cpu_write(addr_a, $urandom, byte_en_t'($urandom_range(15, 1)));
            end else begin
                cpu_read(addr_a);
            end
        end
        end_test();

        start_test("byte_lanes");
        for (int i = 0; i < 7; i++) begin
            addr_a = addr_t'($urandom_range(63, 0) * 4);
            cpu_write(addr_a, $urandom, lanes[i]);
            cpu_read(addr_a);
        end
        end_test();

        // same set, other tag, so the dirty word must reach memory
        start_test("dirty_evict");
        for (int i = 0; i < N_CONFLICT; i++) begin
            set_n  = $urandom_range(`L1_N_SETS - 1, 0);
            word_n = $urandom_range(`L1_BLOCK_WORDS - 1, 0);
            tag_a  = $urandom_range(7, 0);
            tag_b  = (tag_a + $urandom_range(7, 1)) % 8;
            addr_a = addr_t'((tag_a * `L1_N_SETS + set_n) * BLOCK_BYTES + word_n * 4);
            addr_b = addr_t'((tag_b * `L1_N_SETS + set_n) * BLOCK_BYTES + word_n * 4);
            cpu_write(addr_a, $urandom, 4'b1111);
            cpu_read(addr_b);
            check_value(cur_test, model[word_index(addr_a)], u_mem.mem[word_index(addr_a)]);
            cpu_read(addr_a);
        end
        end_test();

        start_test("flush_all");
        for (int i = 0; i < N_FLUSH_WR; i++) begin
            addr_a = addr_t'($urandom_range(63, 0) * 4);
            cpu_write(addr_a, $urandom, byte_en_t'($urandom_range(15, 1)));
        end
        prev_done = done_count;
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        wait_flush_done(prev_done + 1, 400);
        repeat (8) @(posedge CLK);
        check_value({cur_test, " pulses"}, prev_done + 1, done_count);
        for (int i = 0; i < 1024; i++) begin
            check_value(cur_test, model[i], u_mem.mem[i]);
        end
        end_test();

        start_test("pass_through");
        for (int i = 0; i < N_PASS; i++) begin
            addr_a = PASS_BASE + addr_t'($urandom_range(63, 0) * 4);
            if ($urandom_range(1, 0) == 1) begin
                cpu_write(addr_a, $urandom, byte_en_t'($urandom_range(15, 1)));
                @(negedge CLK);
                check_value(cur_test, model[word_index(addr_a)], u_mem.mem[word_index(addr_a)]);
            end else begin
                cpu_read(addr_a);
            end
        end
        end_test();

        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verification/mem_responder.sv
// Testbench block memory
`timescale 1ns/1ps
`include "l1_cache_cfg.svh"

module mem_responder #(
    parameter int WORDS = 1024
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::mem_req_t mem_req,
    output l1_cache_pkg::mem_rsp_t mem_rsp
);
    import l1_cache_pkg::*;

    word_t       mem [WORDS];
    logic        active;
    int unsigned left;
    int unsigned pick;
    logic [9:0]  widx;
    logic [9:0]  bidx;

    // word of the request and first word of its block
    assign widx = mem_req.addr[11:2];
    assign bidx = widx & ~10'(`L1_BLOCK_WORDS - 1);

    // fill pattern spreads every address bit
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
        end
    end

    function automatic block_t read_block(logic [9:0] base);
        block_t blk;
        for (int w = 0; w < `L1_BLOCK_WORDS; w++) begin
            blk[w] = mem[base + w];
        end
        return blk;
    endfunction

    task automatic apply_write();
        if (mem_req.addr >= `L1_NONCACHE_START) begin
            // single uncached word, enabled lanes only
            for (int b = 0; b < 4; b++) begin
                if (mem_req.byte_en[b]) begin
                    mem[widx][8*b +: 8] = mem_req.wdata[0][8*b +: 8];
                end
            end
        end else begin
            for (int w = 0; w < `L1_BLOCK_WORDS; w++) begin
                mem[bidx + w] = mem_req.wdata[w];
            end
        end
    endtask

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mem_rsp.busy  <= 1'b1;
            mem_rsp.rdata <= '0;
            active        <= 1'b0;
            left          <= 0;
        end else if (!mem_rsp.busy) begin
            // request completes on this edge
            if (mem_req.wen) begin
                apply_write();
            end
            mem_rsp.busy <= 1'b1;
            active       <= 1'b0;
        end else if (mem_req.ren || mem_req.wen) begin
            if (!active) begin
                pick = $urandom_range(3, 0);
                if (pick == 0) begin
                    mem_rsp.busy  <= 1'b0;
                    mem_rsp.rdata <= read_block(bidx);
                end else begin
                    active <= 1'b1;
                    left   <= pick - 1;
                end
            end else if (left == 0) begin
                mem_rsp.busy  <= 1'b0;
                mem_rsp.rdata <= read_block(bidx);
            end else begin
                left <= left - 1;
            end
        end
    end

endmodule
